// File: qdr_pkg.sv
`default_nettype none

package qdr_pkg;

  // OPB register map, in words from base_addr
  localparam logic [3:0] REG_RESET      = 4'd0;
  localparam logic [3:0] REG_STATUS     = 4'd1;
  localparam logic [3:0] REG_SM_PRB     = 4'd2;
  localparam logic [3:0] REG_CAL_RESULT = 4'd3;

  localparam int TAP_COUNT = 32;  // Taps in the delay line
  localparam int TAP_W     = 5;

  localparam logic [7:0] TRAIN_PATTERN = 8'hD2;  // Sent MSB first, all rotations distinct

  localparam int SETTLE_CYCLES = 4;                     // Wait after each tap move
  localparam int SAMPLE_COUNT  = 16;                    // Two full pattern periods
  localparam int CNT_W         = $clog2(SAMPLE_COUNT);  // Settle and sample counters
  localparam int RESET_STRETCH = 5;                     // In OPB_Clk cycles

  localparam logic [3:0] PHY_IDLE  = 4'd0;
  localparam logic [3:0] PHY_TRAIN = 4'd1;
  localparam logic [3:0] PHY_ALIGN = 4'd2;
  localparam logic [3:0] PHY_DONE  = 4'd3;
  localparam logic [3:0] PHY_FAIL  = 4'd4;

  localparam logic [3:0] TRN_IDLE   = 4'd0;
  localparam logic [3:0] TRN_SETTLE = 4'd1;
  localparam logic [3:0] TRN_SAMPLE = 4'd2;
  localparam logic [3:0] TRN_CENTER = 4'd3;
  localparam logic [3:0] TRN_DONE   = 4'd4;
  localparam logic [3:0] TRN_FAIL   = 4'd5;

  localparam logic [3:0] ALN_IDLE   = 4'd0;
  localparam logic [3:0] ALN_SAMPLE = 4'd1;
  localparam logic [3:0] ALN_DONE   = 4'd2;
  localparam logic [3:0] ALN_FAIL   = 4'd3;

endpackage

`default_nettype wire

// File: qdr_cal_if.sv
`timescale 1ns/1ps
`default_nettype none

interface qdr_cal_if;
  import qdr_pkg::*;

  logic             qdr_reset;    // Already in the qdr_clk domain
  logic             phy_rdy;
  logic             cal_fail;
  logic [3:0]       phy_state;
  logic [3:0]       train_state;
  logic [3:0]       align_state;
  logic [TAP_W-1:0] cal_tap;

  // Register side, which owns the reset
  modport cfg (output qdr_reset,
               input  phy_rdy, cal_fail, phy_state, train_state, align_state, cal_tap);

  // Sequencer side, which reports status and probes
  modport phy (input  qdr_reset,
               output phy_rdy, cal_fail, phy_state, train_state, align_state, cal_tap);

endinterface

`default_nettype wire

// File: qdr_config.sv
`timescale 1ns/1ps
`default_nettype none

module qdr_config #(
  parameter logic [31:0] base_addr = 32'h0000_0000,
  parameter logic [31:0] high_addr = 32'h0000_0010
) (
  input  logic        OPB_Clk,
  input  logic        arst_n,
  input  logic [31:0] opb_abus,
  input  logic [3:0]  opb_be,
  input  logic [31:0] opb_dbus,
  input  logic        opb_rnw,
  input  logic        opb_select,
  output logic [31:0] sl_dbus,
  output logic        sl_xfer_ack,
  input  logic        qdr_clk,
  qdr_cal_if.cfg      cal
);
  import qdr_pkg::*;

  logic [31:0]              opb_offset;
  logic [3:0]               word_sel;
  logic                     opb_hit;
  logic                     ack_q;
  logic                     ack_set;
  logic [3:0]               data_sel;
  logic [RESET_STRETCH-1:0] reset_shift;
  logic                     rst_meta;
  logic                     rst_sync;

  logic             rdy_meta;
  logic             rdy_sync;
  logic             fail_meta;
  logic             fail_sync;
  logic [3:0]       phy_st_meta;
  logic [3:0]       phy_st_sync;
  logic [3:0]       trn_st_meta;
  logic [3:0]       trn_st_sync;
  logic [3:0]       aln_st_meta;
  logic [3:0]       aln_st_sync;
  logic [TAP_W-1:0] tap_meta;
  logic [TAP_W-1:0] tap_sync;

  assign opb_offset = opb_abus - base_addr;
  assign word_sel   = opb_offset[5:2];  // Byte address to word offset
  assign opb_hit    = opb_select && (opb_abus >= base_addr) && (opb_abus < high_addr);
  assign ack_set    = opb_hit && !ack_q;  // No acknowledge right after an acknowledge

  always_ff @(posedge OPB_Clk or negedge arst_n) begin
    if (!arst_n) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= ack_set;
    end
  end

  // Offset held for the read mux during the acknowledge cycle
  always_ff @(posedge OPB_Clk) begin
    if (ack_set) begin
      data_sel <= word_sel;
    end
  end

  always_ff @(posedge OPB_Clk or negedge arst_n) begin
    if (!arst_n) begin
      reset_shift <= '0;
    end else begin
      reset_shift <= {reset_shift[RESET_STRETCH-2:0], 1'b0};  // A loaded one walks out
      if (ack_set && !opb_rnw && (word_sel == REG_RESET) && opb_be[0]) begin
        reset_shift[0] <= opb_dbus[0];
      end
    end
  end

  // The memory side stays in reset while arst_n is low
  always_ff @(posedge qdr_clk or negedge arst_n) begin
    if (!arst_n) begin
      rst_meta <= 1'b1;
      rst_sync <= 1'b1;
    end else begin
      rst_meta <= |reset_shift;  // Stretched pulse is wide enough for qdr_clk
      rst_sync <= rst_meta;
    end
  end

  assign cal.qdr_reset = rst_sync;

  // Status fields are slow levels, two flops each into OPB_Clk
  always_ff @(posedge OPB_Clk or negedge arst_n) begin
    if (!arst_n) begin
      rdy_meta    <= 1'b0;
      rdy_sync    <= 1'b0;
      fail_meta   <= 1'b0;
      fail_sync   <= 1'b0;
      phy_st_meta <= PHY_IDLE;
      phy_st_sync <= PHY_IDLE;
      trn_st_meta <= TRN_IDLE;
      trn_st_sync <= TRN_IDLE;
      aln_st_meta <= ALN_IDLE;
      aln_st_sync <= ALN_IDLE;
      tap_meta    <= '0;
      tap_sync    <= '0;
    end else begin
      rdy_meta    <= cal.phy_rdy;
      rdy_sync    <= rdy_meta;
      fail_meta   <= cal.cal_fail;
      fail_sync   <= fail_meta;
      phy_st_meta <= cal.phy_state;
      phy_st_sync <= phy_st_meta;
      trn_st_meta <= cal.train_state;
      trn_st_sync <= trn_st_meta;
      aln_st_meta <= cal.align_state;
      aln_st_sync <= aln_st_meta;
      tap_meta    <= cal.cal_tap;
      tap_sync    <= tap_meta;
    end
  end

  // Bus stays at zero unless the slave is acknowledging
  always_comb begin
    sl_dbus = '0;
    if (ack_q) begin
      case (data_sel)
        REG_STATUS:     sl_dbus = {23'd0, fail_sync, 7'd0, rdy_sync};
        REG_SM_PRB:     sl_dbus = {8'hFF, 12'd0, phy_st_sync, aln_st_sync, trn_st_sync};
        REG_CAL_RESULT: sl_dbus = {{(32-TAP_W){1'b0}}, tap_sync};
        default:        sl_dbus = '0;  // Reset register and holes read zero
      endcase
    end
  end

  assign sl_xfer_ack = ack_q;

endmodule

`default_nettype wire

// File: qdr_phy_cal.sv
`timescale 1ns/1ps
`default_nettype none

module qdr_phy_cal (
  input  logic                      qdr_clk,
  input  logic                      arst_n,
  input  logic                      dq,
  output logic [qdr_pkg::TAP_W-1:0] tap,
  qdr_cal_if.phy                    cal
);
  import qdr_pkg::*;

  logic [3:0]              phy_state;
  logic [3:0]              trn_state;
  logic [3:0]              aln_state;
  logic                    phy_rdy_q;
  logic                    cal_fail_q;
  logic [TAP_W-1:0]        tap_q;
  logic [TAP_W-1:0]        first_tap;
  logic [TAP_W-1:0]        last_tap;
  logic                    found;
  logic [CNT_W-1:0]        trn_cnt;
  logic [CNT_W-1:0]        aln_cnt;
  logic [SAMPLE_COUNT-1:0] smp;
  logic [SAMPLE_COUNT-1:0] smp_next;
  logic                    tap_pass;
  logic [TAP_W:0]          tap_sum;

  // True when word is the training byte started at any of its eight bit positions
  function automatic logic is_rotation(input logic [7:0] word);
    logic [15:0] twice;
    logic        hit;
    twice = {TRAIN_PATTERN, TRAIN_PATTERN};
    hit   = 1'b0;
    for (int k = 0; k < 8; k++) begin
      if (twice[k +: 8] == word) begin
        hit = 1'b1;
      end
    end
    return hit;
  endfunction

  assign smp_next = {smp[SAMPLE_COUNT-2:0], dq};  // Oldest sample ends up in the MSB
  assign tap_pass = (smp_next[SAMPLE_COUNT-1:8] == smp_next[SAMPLE_COUNT-9:0]) &&
                    (smp_next != '0) && (smp_next != '1);  // Periodic and toggling
  assign tap_sum  = first_tap + last_tap;

  // One shift register serves both sampling states
  always_ff @(posedge qdr_clk) begin
    if ((trn_state == TRN_SAMPLE) || (aln_state == ALN_SAMPLE)) begin
      smp <= smp_next;
    end
  end

  always_ff @(posedge qdr_clk or negedge arst_n) begin
    if (!arst_n) begin
      phy_state  <= PHY_IDLE;
      phy_rdy_q  <= 1'b0;
      cal_fail_q <= 1'b0;
    end else if (cal.qdr_reset) begin
      phy_state  <= PHY_IDLE;
      phy_rdy_q  <= 1'b0;
      cal_fail_q <= 1'b0;
    end else begin
      case (phy_state)
        PHY_IDLE:  phy_state <= PHY_TRAIN;  // Calibration starts once reset drops
        PHY_TRAIN: begin
          if (trn_state == TRN_DONE) begin
            phy_state <= PHY_ALIGN;
          end else if (trn_state == TRN_FAIL) begin
            phy_state  <= PHY_FAIL;
            cal_fail_q <= 1'b1;
          end
        end
        PHY_ALIGN: begin
          if (aln_state == ALN_DONE) begin
            phy_state <= PHY_DONE;
            phy_rdy_q <= 1'b1;
          end else if (aln_state == ALN_FAIL) begin
            phy_state  <= PHY_FAIL;
            cal_fail_q <= 1'b1;
          end
        end
        default: phy_state <= phy_state;  // Done and fail wait for the next reset
      endcase
    end
  end

  always_ff @(posedge qdr_clk or negedge arst_n) begin
    if (!arst_n) begin
      trn_state <= TRN_IDLE;
      tap_q     <= '0;
      first_tap <= '0;
      last_tap  <= '0;
      found     <= 1'b0;
      trn_cnt   <= '0;
    end else if (cal.qdr_reset) begin
      trn_state <= TRN_IDLE;
      tap_q     <= '0;
      first_tap <= '0;
      last_tap  <= '0;
      found     <= 1'b0;
      trn_cnt   <= '0;
    end else begin
      case (trn_state)
        TRN_IDLE: begin
          if (phy_state == PHY_TRAIN) begin
            trn_state <= TRN_SETTLE;
          end
        end
        TRN_SETTLE: begin
          if (trn_cnt == CNT_W'(SETTLE_CYCLES - 1)) begin
            trn_cnt   <= '0;
            trn_state <= TRN_SAMPLE;
          end else begin
            trn_cnt <= trn_cnt + 1'b1;
          end
        end
        TRN_SAMPLE: begin
          if (trn_cnt == CNT_W'(SAMPLE_COUNT - 1)) begin
            trn_cnt <= '0;
            if (tap_pass) begin
              if (!found) begin
                first_tap <= tap_q;
              end
              found    <= 1'b1;
              last_tap <= tap_q;
            end
            if (found && !tap_pass) begin
              trn_state <= TRN_CENTER;  // End of the first passing run
            end else if (tap_q == TAP_W'(TAP_COUNT - 1)) begin
              trn_state <= (found || tap_pass) ? TRN_CENTER : TRN_FAIL;
              tap_q     <= (found || tap_pass) ? tap_q : '0;
            end else begin
              tap_q     <= tap_q + 1'b1;
              trn_state <= TRN_SETTLE;
            end
          end else begin
            trn_cnt <= trn_cnt + 1'b1;
          end
        end
        TRN_CENTER: begin
          tap_q     <= tap_sum[TAP_W:1];  // Floor of the mean of the run edges
          trn_state <= TRN_DONE;
        end
        default: trn_state <= trn_state;
      endcase
    end
  end

  always_ff @(posedge qdr_clk or negedge arst_n) begin
    if (!arst_n) begin
      aln_state <= ALN_IDLE;
      aln_cnt   <= '0;
    end else if (cal.qdr_reset) begin
      aln_state <= ALN_IDLE;
      aln_cnt   <= '0;
    end else begin
      case (aln_state)
        ALN_IDLE: begin
          if (phy_state == PHY_ALIGN) begin  // Settle at the centre tap first
            if (aln_cnt == CNT_W'(SETTLE_CYCLES - 1)) begin
              aln_cnt   <= '0;
              aln_state <= ALN_SAMPLE;
            end else begin
              aln_cnt <= aln_cnt + 1'b1;
            end
          end
        end
        ALN_SAMPLE: begin
          if (aln_cnt == CNT_W'(7)) begin
            aln_state <= is_rotation(smp_next[7:0]) ? ALN_DONE : ALN_FAIL;
          end else begin
            aln_cnt <= aln_cnt + 1'b1;
          end
        end
        default: aln_state <= aln_state;
      endcase
    end
  end

  assign tap             = tap_q;
  assign cal.cal_tap     = tap_q;
  assign cal.phy_rdy     = phy_rdy_q;
  assign cal.cal_fail    = cal_fail_q;
  assign cal.phy_state   = phy_state;
  assign cal.train_state = trn_state;
  assign cal.align_state = aln_state;

endmodule

`default_nettype wire

// File: qdr_cal_top.sv
`timescale 1ns/1ps
`default_nettype none

module qdr_cal_top #(
  parameter logic [31:0] base_addr = 32'h0000_0000,
  parameter logic [31:0] high_addr = 32'h0000_0010
) (
  input  logic                      OPB_Clk,
  input  logic                      arst_n,
  input  logic                      qdr_clk,
  input  logic [31:0]               opb_abus,
  input  logic [3:0]                opb_be,
  input  logic [31:0]               opb_dbus,
  input  logic                      opb_rnw,
  input  logic                      opb_select,
  output logic [31:0]               sl_dbus,
  output logic                      sl_xfer_ack,
  input  logic                      dq,
  output logic [qdr_pkg::TAP_W-1:0] tap
);

  // Reset, status and probes between the two clock domains
  qdr_cal_if cal_if ();

  qdr_config #(
    .base_addr (base_addr),
    .high_addr (high_addr)
  ) qdr_config_inst (
    .OPB_Clk     (OPB_Clk),
    .arst_n      (arst_n),
    .opb_abus    (opb_abus),
    .opb_be      (opb_be),
    .opb_dbus    (opb_dbus),
    .opb_rnw     (opb_rnw),
    .opb_select  (opb_select),
    .sl_dbus     (sl_dbus),
    .sl_xfer_ack (sl_xfer_ack),
    .qdr_clk     (qdr_clk),
    .cal         (cal_if.cfg)
  );

  qdr_phy_cal qdr_phy_cal_inst (
    .qdr_clk (qdr_clk),
    .arst_n  (arst_n),
    .dq      (dq),
    .tap     (tap),
    .cal     (cal_if.phy)
  );

endmodule

`default_nettype wire

// File: tb_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
  parameter real period_ns = 10.0,
  parameter real offset_ns = 0.0
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
    #(offset_ns);  // Lets two generators run with a fixed phase between them
    forever begin
      #(period_ns / 2.0) clk = ~clk;
    end
  end

endmodule

`default_nettype wire

// File: tb_qdr_cal.sv
`timescale 1ns/1ps
`default_nettype none

module tb_qdr_cal;
  import qdr_pkg::*;

  localparam int          NUM_VEC      = 16;
  localparam int          ACK_TIMEOUT  = 16;   // OPB_Clk cycles per bus transfer
  localparam int          POLL_LIMIT   = 2000;  // Status reads per poll
  localparam int          NOACK_CYCLES = 20;
  localparam logic [31:0] BASE_ADDR    = 32'h0000_1000;
  localparam logic [31:0] HIGH_ADDR    = 32'h0000_1010;
  localparam logic [31:0] OUTSIDE_ADDR = 32'h0000_2000;

  logic             OPB_Clk;
  logic             qdr_clk;
  logic             arst_n;
  logic [31:0]      opb_abus;
  logic [3:0]       opb_be;
  logic [31:0]      opb_dbus;
  logic             opb_rnw;
  logic             opb_select;
  logic [31:0]      sl_dbus;
  logic             sl_xfer_ack;
  logic             dq = 1'b0;
  logic [TAP_W-1:0] tap;

  logic [7:0]  vec_mem [0:NUM_VEC*8-1];  // Eight fields per calibration case
  logic [7:0]  win_lo;
  logic [7:0]  win_hi;
  logic [7:0]  cur_pattern;
  logic [2:0]  bit_cnt = 3'd0;
  logic [7:0]  exp_fail;
  logic [7:0]  exp_tap;
  logic [7:0]  exp_trn;
  logic [7:0]  exp_aln;
  logic [7:0]  exp_phy;
  string       tname;

  tb_clk_gen #(.period_ns(10.0), .offset_ns(0.0)) opb_clk_gen_inst (.clk(OPB_Clk));
  tb_clk_gen #(.period_ns(10.0), .offset_ns(3.0)) qdr_clk_gen_inst (.clk(qdr_clk));

  qdr_cal_top #(
    .base_addr (BASE_ADDR),
    .high_addr (HIGH_ADDR)
  ) qdr_cal_top_inst (
    .OPB_Clk     (OPB_Clk),
    .arst_n      (arst_n),
    .qdr_clk     (qdr_clk),
    .opb_abus    (opb_abus),
    .opb_be      (opb_be),
    .opb_dbus    (opb_dbus),
    .opb_rnw     (opb_rnw),
    .opb_select  (opb_select),
    .sl_dbus     (sl_dbus),
    .sl_xfer_ack (sl_xfer_ack),
    .dq          (dq),
    .tap         (tap)
  );

  // The delay line shows the pattern only while the tap sits inside the window
  always @(negedge qdr_clk) begin
    bit_cnt <= bit_cnt + 3'd1;
    if (({3'd0, tap} >= win_lo) && ({3'd0, tap} <= win_hi)) begin
      dq <= cur_pattern[3'd7 - bit_cnt];  // MSB first
    end else begin
      dq <= 1'b0;
    end
  end

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      $display("FAILED %s: expected %h, actual %h", name, expected, actual);
      $display("TB FAILED");
      $fatal(1, "Value mismatch in %s", name);
    end
  endtask

  task automatic report_timeout(input string what);
    $display("Timed out while waiting for %s", what);
    $display("TB FAILED");
    $fatal(1, "Timeout on %s", what);
  endtask

  task automatic bus_idle();
    opb_select = 1'b0;
    opb_abus   = '0;
    opb_dbus   = '0;
    opb_be     = '0;
    opb_rnw    = 1'b0;
  endtask

  task automatic opb_write(input logic [31:0] addr, input logic [31:0] data,
                           input logic [3:0] be);
    int   waited;
    logic acked;
    waited = 0;
    acked  = 1'b0;
    @(negedge OPB_Clk);
    opb_abus   = addr;
    opb_dbus   = data;
    opb_be     = be;
    opb_rnw    = 1'b0;
    opb_select = 1'b1;
    while (!acked && (waited < ACK_TIMEOUT)) begin
      @(negedge OPB_Clk);
      acked  = sl_xfer_ack;
      waited = waited + 1;
    end
    bus_idle();
    if (!acked) begin
      report_timeout("the write acknowledge");
    end
  endtask

  task automatic opb_read(input logic [31:0] addr, output logic [31:0] data);
    int   waited;
    logic acked;
    waited = 0;
    acked  = 1'b0;
    data   = '0;
    @(negedge OPB_Clk);
    check_value("sl_dbus between transfers", 32'd0, sl_dbus);  // Previous acknowledge is over
    opb_abus   = addr;
    opb_be     = 4'hF;
    opb_rnw    = 1'b1;
    opb_select = 1'b1;
    while (!acked && (waited < ACK_TIMEOUT)) begin
      @(negedge OPB_Clk);
      acked  = sl_xfer_ack;
      waited = waited + 1;
      if (acked) begin
        data = sl_dbus;
      end
    end
    bus_idle();
    if (!acked) begin
      report_timeout("the read acknowledge");
    end
  endtask

  task automatic read_check(input string name, input logic [31:0] addr,
                            input logic [31:0] expected);
    logic [31:0] data;
    opb_read(addr, data);
    check_value(name, expected, data);
  endtask

  // Polls REG_STATUS until it is clear, or until ready or fail shows up
  task automatic wait_status(input logic want_done, input string what);
    int          polls;
    logic        reached;
    logic [31:0] status;
    polls   = 0;
    reached = 1'b0;
    while (!reached && (polls < POLL_LIMIT)) begin
      opb_read(BASE_ADDR + {26'd0, REG_STATUS, 2'b00}, status);
      reached = want_done ? (status[0] || status[8]) : (status == 32'd0);
      polls   = polls + 1;
    end
    if (!reached) begin
      report_timeout(what);
    end
  endtask

  task automatic check_no_ack();
    @(negedge OPB_Clk);
    opb_abus   = OUTSIDE_ADDR;
    opb_be     = 4'hF;
    opb_rnw    = 1'b1;
    opb_select = 1'b1;
    for (int i = 0; i < NOACK_CYCLES; i++) begin
      @(negedge OPB_Clk);
      check_value("no acknowledge outside window", 32'd0, {31'd0, sl_xfer_ack});
      check_value("sl_dbus outside window", 32'd0, sl_dbus);
    end
    bus_idle();
  endtask

  initial begin
    arst_n      = 1'b0;
    win_lo      = 8'hFF;  // Empty window during the power-on calibration
    win_hi      = 8'h00;
    cur_pattern = TRAIN_PATTERN;
    bus_idle();
    $readmemh("qdr_cal_vectors.txt", vec_mem);
    repeat (16) @(posedge OPB_Clk);
    @(negedge OPB_Clk);
    arst_n = 1'b1;

    // Probes are read first, before the sequencer leaves its IDLE codes
    read_check("probes after reset", BASE_ADDR + {26'd0, REG_SM_PRB, 2'b00}, 32'hFF00_0000);
    read_check("status after reset", BASE_ADDR + {26'd0, REG_STATUS, 2'b00}, 32'd0);
    read_check("reset register reads zero", BASE_ADDR, 32'd0);
    read_check("byte offset 7", BASE_ADDR + 32'd7, 32'd0);
    check_no_ack();

    for (int v = 0; v < NUM_VEC; v++) begin
      @(negedge OPB_Clk);
      win_lo      = vec_mem[v*8];
      win_hi      = vec_mem[v*8+1];
      cur_pattern = vec_mem[v*8+2];
      exp_fail    = vec_mem[v*8+3];
      exp_tap     = vec_mem[v*8+4];
      exp_trn     = vec_mem[v*8+5];
      exp_aln     = vec_mem[v*8+6];
      exp_phy     = vec_mem[v*8+7];
      opb_write(BASE_ADDR + {26'd0, REG_RESET, 2'b00}, 32'd1, 4'h1);
      wait_status(1'b0, $sformatf("status to clear in vector %0d", v));
      wait_status(1'b1, $sformatf("calibration end in vector %0d", v));
      tname = $sformatf("vector %0d status", v);
      read_check(tname, BASE_ADDR + {26'd0, REG_STATUS, 2'b00},
                 {23'd0, exp_fail[0], 7'd0, !exp_fail[0]});
      tname = $sformatf("vector %0d tap", v);
      read_check(tname, BASE_ADDR + {26'd0, REG_CAL_RESULT, 2'b00}, {24'd0, exp_tap});
      check_value(tname, {24'd0, exp_tap}, {27'd0, tap});  // Tap port matches the register
      tname = $sformatf("vector %0d probes", v);
      read_check(tname, BASE_ADDR + {26'd0, REG_SM_PRB, 2'b00},
                 {8'hFF, 12'd0, exp_phy[3:0], exp_aln[3:0], exp_trn[3:0]});
    end

    $display("TB PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// File: qdr_cal_vectors.txt
// win_lo win_hi pattern exp_fail exp_tap exp_train exp_align exp_phy (all hex)
// An empty window has win_lo above win_hi
04 0b d2 0 07 4 2 3
00 03 d2 0 01 4 2 3
18 1f d2 0 1b 4 2 3
1c 28 d2 0 1d 4 2 3
1f 1f d2 0 1f 4 2 3
0a 0a d2 0 0a 4 2 3
00 1f d2 0 0f 4 2 3
10 11 d2 0 10 4 2 3
05 09 a5 0 07 4 2 3
13 17 69 0 15 4 2 3
0a 09 d2 1 00 5 0 4
05 09 00 1 00 5 0 4
05 09 ff 1 00 5 0 4
06 0d aa 1 09 4 3 4
00 1f aa 1 0f 4 3 4
02 06 d2 0 04 4 2 3

// File: files.f
qdr_pkg.sv
qdr_cal_if.sv
qdr_config.sv
qdr_phy_cal.sv
qdr_cal_top.sv
tb_clk_gen.sv
tb_qdr_cal.sv

// File: run.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_qdr_cal -f files.f -o tb_qdr_cal
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

output=$(./obj_dir/tb_qdr_cal)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -q "^TB PASSED$"; then
  exit 0
fi
exit 1
